/* vlog.f */
erx_pkg.sv
erx_protocol.sv
erx_remap.sv
erx_fifo.sv
erx_distributor.sv
erx_cfg.sv
erx_core.sv
tb_erx_core.sv

/* tb_erx_core.sv */
`timescale 1ns/1ns

module tb_erx_core
   import erx_pkg::*;
();

   localparam int NUM_PKTS = 91;      // Link plus cfg packets in the run
   localparam int CLK_HALF = 10;

   logic            clk;
   logic            reset;
   logic            rx_access;
   logic [PW-1:0]   rx_packet;
   logic            rxwr_wait;
   logic            rxrd_wait;
   logic            rxrr_wait;
   logic            erx_cfg_access;
   logic [PW-1:0]   erx_cfg_packet;
   logic            rx_wait;
   logic            rxwr_access;
   logic [PW-1:0]   rxwr_packet;
   logic            rxrd_access;
   logic [PW-1:0]   rxrd_packet;
   logic            rxrr_access;
   logic [PW-1:0]   rxrr_packet;
   logic            erx_cfg_wait;
   logic            mailbox_irq;

   logic [PW-1:0]   exp_q [3][$];     // Expected packets, one queue per class
   logic [31:0]     lfsr = 32'hb75a_8758;
   int              value_errs;
   int              other_errs;
   int              sent;             // Link packets since last clear
   logic            lat_chk;          // Idle pipe, exact latency expected
   logic            hold_wr;          // Long stall on rxwr
   logic            rand_waits;
   logic            remap_on;         // Model of REG_CFG and remap registers
   logic            tm_on;
   logic [ID_W-1:0] map_sel;
   logic [ID_W-1:0] map_pat;
   logic [DW-1:0]   tm_sum;

   erx_core dut0 (.*);

   always #CLK_HALF clk = ~clk;

   // Galois LFSR, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [PW-1:0] rand_packet(input logic [1:0] cls);
      logic [ID_W-1:0] hi;
      hi = ID_W'(rand_bits(ID_W));
      if (hi == ELINK_ID) begin
         hi = ~hi;                    // Keep writes and reads off our own id
      end
      if (cls == CLASS_RR) begin
         hi = ELINK_ID;
      end
      return {cls != CLASS_RD, DATAMODE_32, 5'(rand_bits(5)), hi, 20'(rand_bits(20)),
              rand_bits(32), rand_bits(32)};
   endfunction

   task automatic compare_head(input int ch, input string name, input logic [PW-1:0] act);
      logic [PW-1:0] exp;
      if (exp_q[ch].size() == 0) begin
         other_errs++;
         $display("Unexpected packet on %s at %0t", name, $time);
      end else begin
         exp = exp_q[ch].pop_front();
         assert (act == exp) else begin
            value_errs++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
         end
      end
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      assert (act == exp) else begin
         value_errs++;
         $display("[FAIL] %0t %s expected %0b got %0b", $time, name, exp, act);
      end
   endtask

   task automatic report_stall(input string name);
      other_errs++;
      $display("%s dropped or changed its packet while wait was high at %0t", name, $time);
   endtask

   task automatic send_packet(input logic [1:0] cls);
      logic [PW-1:0]   pkt;
      logic [PW-1:0]   exp;
      logic [ID_W-1:0] hi;
      pkt = rand_packet(cls);
      hi  = pkt[DST_HI -: ID_W];
      exp = pkt;
      @(posedge clk);
      while (rx_wait) begin          // Far end honors the advisory wait
         @(posedge clk);
      end
      rx_access <= 1'b1;
      rx_packet <= pkt;
      if (tm_on) begin
         tm_sum = tm_sum + ((cls != CLASS_RD) ? pkt[DATA_HI:DATA_LO] : 32'd0);
      end else begin
         if (remap_on && cls != CLASS_RR) begin
            exp[DST_HI -: ID_W] = (map_pat & map_sel) | (hi & ~map_sel);
         end
         exp_q[cls].push_back(exp);
      end
      sent++;
      @(posedge clk);
      rx_access <= 1'b0;
   endtask

   task automatic put_cfg(input logic [PW-1:0] pkt);
      @(posedge clk);
      while (erx_cfg_wait) begin
         @(posedge clk);
      end
      erx_cfg_access <= 1'b1;
      erx_cfg_packet <= pkt;
      @(posedge clk);                // Accepted on this edge
      erx_cfg_access <= 1'b0;
   endtask

   // Nonzero upper word makes it a 64-bit write
   task automatic write_reg(input logic [3:0] ra, input logic [31:0] lo, input logic [31:0] hi);
      put_cfg({1'b1, (hi != 0) ? DATAMODE_64 : DATAMODE_32, 5'd0, 26'd0, ra, 2'b00, lo, hi});
   endtask

   task automatic read_reg(input logic [3:0] ra, input logic [31:0] exp_data);
      logic [31:0] ret;
      ret = rand_bits(32);
      exp_q[CLASS_RR].push_back({1'b1, DATAMODE_32, 5'd0, ret, exp_data, 26'd0, ra, 2'b00});
      put_cfg({1'b0, DATAMODE_32, 5'd0, 26'd0, ra, 2'b00, 32'd0, ret});
   endtask

   task automatic drain();
      while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
   endtask

   always @(posedge clk) begin
      rxwr_wait <= hold_wr | (rand_waits && rand_bits(1) != 0);
      rxrd_wait <= rand_waits && rand_bits(1) != 0;
      rxrr_wait <= rand_waits && rand_bits(1) != 0;
   end

   // Scoreboard on every accepted transfer
   always @(posedge clk) begin
      if (!reset) begin
         if (rxwr_access && !rxwr_wait) begin
            compare_head(CLASS_WR, "rxwr_packet", rxwr_packet);
         end
         if (rxrd_access && !rxrd_wait) begin
            compare_head(CLASS_RD, "rxrd_packet", rxrd_packet);
         end
         if (rxrr_access && !rxrr_wait) begin
            compare_head(CLASS_RR, "rxrr_packet", rxrr_packet);
         end
      end
   end

   assert property (@(posedge clk) $fell(reset) |->
                    !(rxwr_access || rxrd_access || rxrr_access || rx_wait || erx_cfg_wait ||
                      mailbox_irq))
      else begin
         other_errs++;
         $display("An access, wait or interrupt output was not 0 after reset at %0t", $time);
      end
   assert property (@(posedge clk) disable iff (reset)
                    rxwr_access && rxwr_wait |=> rxwr_access && $stable(rxwr_packet))
      else report_stall("rxwr");
   assert property (@(posedge clk) disable iff (reset)
                    rxrd_access && rxrd_wait |=> rxrd_access && $stable(rxrd_packet))
      else report_stall("rxrd");
   assert property (@(posedge clk) disable iff (reset)
                    rxrr_access && rxrr_wait |=> rxrr_access && $stable(rxrr_packet))
      else report_stall("rxrr");
   assert property (@(posedge clk) disable iff (reset)
                    lat_chk && rx_access |-> ##4 rxwr_access && rxwr_packet == $past(rx_packet, 4))
      else begin
         other_errs++;
         $display("Write missed rxwr four cycles after input at %0t", $time);
      end

   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      rx_access      = 1'b0;
      rx_packet      = '0;
      erx_cfg_access = 1'b0;
      erx_cfg_packet = '0;
      rxwr_wait      = 1'b0;
      rxrd_wait      = 1'b0;
      rxrr_wait      = 1'b0;
      value_errs     = 0;
      other_errs     = 0;
      sent           = 0;
      lat_chk        = 1'b0;
      hold_wr        = 1'b0;
      rand_waits     = 1'b0;
      remap_on       = 1'b0;
      tm_on          = 1'b0;
      map_sel        = 12'hf0f;
      map_pat        = 12'ha5c;
      tm_sum         = '0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      @(posedge clk);
      lat_chk <= 1'b1;               // Writes straight through an empty pipe
      repeat (6) send_packet(CLASS_WR);
      @(posedge clk);
      lat_chk <= 1'b0;
      drain();
      repeat (12) send_packet(2'(rand_bits(2) % 3));
      drain();

      write_reg(REG_REMAP_SEL, 32'(map_sel), 32'h0);
      write_reg(REG_REMAP_PATTERN, 32'(map_pat), 32'h0);
      write_reg(REG_CFG, 32'h2, 32'h0);
      remap_on = 1'b1;
      read_reg(REG_REMAP_SEL, 32'(map_sel));
      drain();
      repeat (8) send_packet(2'(rand_bits(2) % 3));
      drain();
      write_reg(REG_CFG, 32'h0, 32'h0);
      remap_on = 1'b0;

      @(posedge clk);
      hold_wr <= 1'b1;               // One packet parks in rxwr, rest fill the FIFO
      sent = 0;
      repeat (6) send_packet(CLASS_WR);
      repeat (4) @(posedge clk);
      check_bit("rx_wait", rx_wait, (sent - 1) >= FIFO_HIGH_WATER);
      send_packet(CLASS_WR);
      repeat (4) @(posedge clk);
      check_bit("rx_wait", rx_wait, (sent - 1) >= FIFO_HIGH_WATER);
      hold_wr <= 1'b0;
      drain();
      @(posedge clk);
      rand_waits <= 1'b1;
      repeat (40) send_packet(2'(rand_bits(2) % 3));
      drain();
      rand_waits <= 1'b0;

      write_reg(REG_CFG, 32'h4, 32'h0);
      read_reg(REG_CFG, 32'h4);
      write_reg(REG_MAILBOX_LO, 32'h1234_5678, 32'h89ab_0001);
      @(posedge clk);
      check_bit("mailbox_irq", mailbox_irq, 1'b1);
      read_reg(REG_MAILBOX_HI, 32'h89ab_0001);
      @(posedge clk);
      check_bit("mailbox_irq", mailbox_irq, 1'b0);
      drain();

      write_reg(REG_CFG, 32'h1, 32'h0);
      tm_on = 1'b1;                  // Link traffic only feeds the checksum
      repeat (6) send_packet(2'(rand_bits(2) % 3));
      repeat (4) @(posedge clk);
      read_reg(REG_TEST_DATA, tm_sum);
      write_reg(REG_CFG, 32'h0, 32'h0);
      tm_on = 1'b0;
      drain();

      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      #((NUM_PKTS * 40 + 200) * 2 * CLK_HALF);
      $display("Timeout, the run did not finish in time");
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* erx_core.sv */
`timescale 1ns/1ns

module erx_core
   import erx_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          rx_access,
   input  logic [PW-1:0] rx_packet,
   input  logic          rxwr_wait,
   input  logic          rxrd_wait,
   input  logic          rxrr_wait,
   input  logic          erx_cfg_access,
   input  logic [PW-1:0] erx_cfg_packet,
   output logic          rx_wait,
   output logic          rxwr_access,
   output logic [PW-1:0] rxwr_packet,
   output logic          rxrd_access,
   output logic [PW-1:0] rxrd_packet,
   output logic          rxrr_access,
   output logic [PW-1:0] rxrr_packet,
   output logic          erx_cfg_wait,
   output logic          mailbox_irq
);

   logic               proto_access;    // Protocol to remap
   logic [1:0]         proto_class;
   logic [PW-1:0]      proto_packet;
   logic [DW-1:0]      test_data;
   logic               remap_access;    // Remap to FIFO
   logic [1:0]         remap_class;
   logic [PW-1:0]      remap_packet;
   logic               fifo_valid;      // FIFO head to distributor
   logic [1:0]         fifo_class;
   logic [PW-1:0]      fifo_packet;
   logic               fifo_pop;
   logic [FIFO_CW-1:0] fifo_count;
   logic               cfg_rsp_access;  // Register read responses
   logic [PW-1:0]      cfg_rsp_packet;
   logic               cfg_rsp_wait;
   logic               test_mode;       // Register settings
   logic               remap_enable;
   logic [ID_W-1:0]    remap_sel;
   logic [ID_W-1:0]    remap_pattern;

   // Port names match the nets throughout
   erx_protocol erx_protocol (.*);

   erx_remap erx_remap (.*);

   erx_fifo erx_fifo (.*);

   erx_distributor erx_distributor (.*);

   erx_cfg erx_cfg (.*);

endmodule

/* erx_cfg.sv */
`timescale 1ns/1ns

module erx_cfg
   import erx_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               erx_cfg_access,
   input  logic [PW-1:0]      erx_cfg_packet,
   input  logic               cfg_rsp_wait,
   input  logic [DW-1:0]      test_data,
   input  logic [FIFO_CW-1:0] fifo_count,
   input  logic               rx_wait,
   input  logic               rxwr_wait,
   input  logic               rxrd_wait,
   input  logic               rxrr_wait,
   output logic               erx_cfg_wait,
   output logic               cfg_rsp_access,
   output logic [PW-1:0]      cfg_rsp_packet,
   output logic               test_mode,
   output logic               remap_enable,
   output logic [ID_W-1:0]    remap_sel,
   output logic [ID_W-1:0]    remap_pattern,
   output logic               mailbox_irq
);

   erx_srcfield_u cfg_src;       // Return address or upper data
   logic          cfg_accept;
   logic          cfg_write;
   logic          cfg_wide;      // 64-bit transaction
   logic [3:0]    reg_addr;
   logic [DW-1:0] cfg_data;
   logic [DW-1:0] rd_data;
   logic [DW-1:0] status_word;
   logic [2:0]    cfg_reg;       // test_mode, remap_enable, irq enable
   logic          mailbox_irq_en;
   logic [DW-1:0] mailbox_lo;
   logic [DW-1:0] mailbox_hi;
   logic          mailbox_full;
   logic [PW-1:0] rsp_packet;

   assign erx_cfg_wait = cfg_rsp_access;    // One read outstanding at a time
   assign cfg_accept   = erx_cfg_access & ~erx_cfg_wait;
   assign cfg_write    = erx_cfg_packet[WRITE_BIT];
   assign cfg_wide     = (erx_cfg_packet[DATAMODE_HI:DATAMODE_LO] == DATAMODE_64);
   assign reg_addr     = erx_cfg_packet[REG_ADDR_HI:REG_ADDR_LO];
   assign cfg_data     = erx_cfg_packet[DATA_HI:DATA_LO];
   assign cfg_src      = erx_cfg_packet[SRC_HI:SRC_LO];

   assign test_mode      = cfg_reg[CFG_TEST_MODE];
   assign remap_enable   = cfg_reg[CFG_REMAP_EN];
   assign mailbox_irq_en = cfg_reg[CFG_IRQ_EN];
   assign mailbox_irq    = mailbox_full & mailbox_irq_en;

   assign status_word = DW'({fifo_count, rx_wait, rxrr_wait, rxrd_wait, rxwr_wait});

   always_comb begin
      case (reg_addr)
         REG_CFG:           rd_data = DW'(cfg_reg);
         REG_REMAP_SEL:     rd_data = DW'(remap_sel);
         REG_REMAP_PATTERN: rd_data = DW'(remap_pattern);
         REG_STATUS:        rd_data = status_word;
         REG_TEST_DATA:     rd_data = test_data;
         REG_MAILBOX_LO:    rd_data = mailbox_lo;
         REG_MAILBOX_HI:    rd_data = mailbox_hi;
         default:           rd_data = '0;     // Unmapped reads as zero
      endcase
   end

   // Response is a 32-bit write back to the requester
   always_comb begin
      rsp_packet                           = '0;
      rsp_packet[WRITE_BIT]                = 1'b1;
      rsp_packet[DATAMODE_HI:DATAMODE_LO]  = DATAMODE_32;
      rsp_packet[CTRLMODE_HI:CTRLMODE_LO]  = erx_cfg_packet[CTRLMODE_HI:CTRLMODE_LO];
      rsp_packet[DST_HI:DST_LO]            = cfg_src.rd_return_addr;
      rsp_packet[DATA_HI:DATA_LO]          = rd_data;
      rsp_packet[SRC_HI:SRC_LO]            = erx_cfg_packet[DST_HI:DST_LO];  // Register echoed
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_reg        <= '0;
         remap_sel      <= '0;
         remap_pattern  <= '0;
         mailbox_lo     <= '0;
         mailbox_hi     <= '0;
         mailbox_full   <= 1'b0;
         cfg_rsp_access <= 1'b0;
      end else begin
         if (cfg_rsp_access && !cfg_rsp_wait) begin
            cfg_rsp_access <= 1'b0;           // Taken by distributor
         end
         if (cfg_accept && !cfg_write) begin
            cfg_rsp_access <= 1'b1;
            if (reg_addr == REG_MAILBOX_HI) begin
               mailbox_full <= 1'b0;          // Upper word read drains mailbox
            end
         end
         if (cfg_accept && cfg_write) begin
            case (reg_addr)
               REG_CFG:           cfg_reg       <= cfg_data[2:0];
               REG_REMAP_SEL:     remap_sel     <= cfg_data[ID_W-1:0];
               REG_REMAP_PATTERN: remap_pattern <= cfg_data[ID_W-1:0];
               REG_MAILBOX_LO: begin
                  mailbox_lo   <= cfg_data;
                  mailbox_full <= 1'b1;
                  if (cfg_wide) begin
                     mailbox_hi <= cfg_src.wr_data_hi;
                  end
               end
               REG_MAILBOX_HI:    mailbox_hi    <= cfg_data;
               default:           ;           // Status and test data read-only
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_accept && !cfg_write) begin
         cfg_rsp_packet <= rsp_packet;
      end
   end

endmodule

/* erx_distributor.sv */
`timescale 1ns/1ns

module erx_distributor
   import erx_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          fifo_valid,
   input  logic [1:0]    fifo_class,
   input  logic [PW-1:0] fifo_packet,
   input  logic          cfg_rsp_access,
   input  logic [PW-1:0] cfg_rsp_packet,
   input  logic          rxwr_wait,
   input  logic          rxrd_wait,
   input  logic          rxrr_wait,
   output logic          fifo_pop,
   output logic          cfg_rsp_wait,
   output logic          rxwr_access,
   output logic [PW-1:0] rxwr_packet,
   output logic          rxrd_access,
   output logic [PW-1:0] rxrd_packet,
   output logic          rxrr_access,
   output logic [PW-1:0] rxrr_packet
);

   // Channel arrays indexed by class code
   logic [2:0]    ch_access;
   logic [2:0]    ch_wait;
   logic [2:0]    ch_load;
   logic [3:0]    ch_free;        // Entry 3 is an unused class code
   logic [PW-1:0] ch_packet [3];
   logic          cfg_load;
   logic          head_free;

   assign ch_wait[CLASS_WR] = rxwr_wait;
   assign ch_wait[CLASS_RD] = rxrd_wait;
   assign ch_wait[CLASS_RR] = rxrr_wait;

   // Empty, or emptied by a transfer on this edge
   assign ch_free[2:0] = ~ch_access | ~ch_wait;
   assign ch_free[3]   = 1'b0;

   assign cfg_load     = cfg_rsp_access & ch_free[CLASS_RR];  // Config wins rxrr
   assign cfg_rsp_wait = ~ch_free[CLASS_RR];

   // Head of line blocks until its own channel frees
   assign head_free = ch_free[fifo_class] & ~(cfg_rsp_access & (fifo_class == CLASS_RR));
   assign fifo_pop  = fifo_valid & head_free;

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         ch_load[i] = fifo_pop & (fifo_class == 2'(i));
      end
      ch_load[CLASS_RR] = ch_load[CLASS_RR] | cfg_load;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ch_access <= '0;
      end else begin
         ch_access <= ch_load | (ch_access & ch_wait);  // Hold while stalled
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < 3; i++) begin
         if (ch_load[i]) begin
            ch_packet[i] <= fifo_packet;
         end
      end
      if (cfg_load) begin
         ch_packet[CLASS_RR] <= cfg_rsp_packet;  // FIFO rr head held off this cycle
      end
   end

   assign rxwr_access = ch_access[CLASS_WR];
   assign rxwr_packet = ch_packet[CLASS_WR];
   assign rxrd_access = ch_access[CLASS_RD];
   assign rxrd_packet = ch_packet[CLASS_RD];
   assign rxrr_access = ch_access[CLASS_RR];
   assign rxrr_packet = ch_packet[CLASS_RR];

endmodule

/* erx_fifo.sv */
`timescale 1ns/1ns

module erx_fifo
   import erx_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               remap_access,
   input  logic [1:0]         remap_class,
   input  logic [PW-1:0]      remap_packet,
   input  logic               fifo_pop,
   output logic               fifo_valid,
   output logic [1:0]         fifo_class,
   output logic [PW-1:0]      fifo_packet,
   output logic [FIFO_CW-1:0] fifo_count,
   output logic               rx_wait
);

   logic [PW+1:0]      mem [FIFO_DEPTH];  // Class in top two bits
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic               push;
   logic               pop;

   assign fifo_valid = (fifo_count != '0);
   assign pop        = fifo_pop & fifo_valid;
   // Full FIFO still takes a write if the head leaves this cycle
   assign push       = remap_access & ((fifo_count != FIFO_CW'(FIFO_DEPTH)) | pop);

   assign {fifo_class, fifo_packet} = mem[rd_ptr];   // Head shown directly

   // Advisory to far end, two packets may still be in the pipe
   assign rx_wait = (fifo_count >= FIFO_CW'(FIFO_HIGH_WATER));

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;    // Depth is power of two, wraps
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   fifo_count <= fifo_count + 1'b1;
            2'b01:   fifo_count <= fifo_count - 1'b1;
            default: fifo_count <= fifo_count;  // Idle or push and pop together
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {remap_class, remap_packet};
      end
   end

endmodule

/* erx_remap.sv */
`timescale 1ns/1ns

module erx_remap
   import erx_pkg::*;
(
   input  logic            clk,
   input  logic            reset,
   input  logic            proto_access,
   input  logic [1:0]      proto_class,
   input  logic [PW-1:0]   proto_packet,
   input  logic            remap_enable,
   input  logic [ID_W-1:0] remap_sel,
   input  logic [ID_W-1:0] remap_pattern,
   output logic            remap_access,
   output logic [1:0]      remap_class,
   output logic [PW-1:0]   remap_packet
);

   logic [ID_W-1:0] addr_hi;      // Top dstaddr bits in
   logic [ID_W-1:0] addr_hi_new;  // After select mask
   logic            do_remap;
   logic [PW-1:0]   packet_mapped;

   assign addr_hi     = proto_packet[DST_LO+AW-1 -: ID_W];
   assign addr_hi_new = (remap_pattern & remap_sel) | (addr_hi & ~remap_sel);
   assign do_remap    = remap_enable & (proto_class != CLASS_RR);  // Responses untouched

   always_comb begin
      packet_mapped = proto_packet;
      if (do_remap) begin
         packet_mapped[DST_LO+AW-1 -: ID_W] = addr_hi_new;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         remap_access <= 1'b0;
      end else begin
         remap_access <= proto_access;
      end
   end

   always_ff @(posedge clk) begin
      if (proto_access) begin
         remap_class  <= proto_class;     // Class rides along
         remap_packet <= packet_mapped;
      end
   end

endmodule

/* erx_protocol.sv */
`timescale 1ns/1ns

module erx_protocol
   import erx_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          rx_access,
   input  logic [PW-1:0] rx_packet,
   input  logic          test_mode,
   output logic          proto_access,
   output logic [1:0]    proto_class,
   output logic [PW-1:0] proto_packet,
   output logic [DW-1:0] test_data
);

   logic       rx_write;   // Write bit of incoming packet
   logic       rx_to_me;   // Destination is this chip
   logic [1:0] rx_class;   // Decoded class

   assign rx_write = rx_packet[WRITE_BIT];
   assign rx_to_me = (rx_packet[DST_HI -: ID_W] == ELINK_ID);

   // Writes back to our own id are responses to our reads
   always_comb begin
      if (!rx_write) begin
         rx_class = CLASS_RD;
      end else if (rx_to_me) begin
         rx_class = CLASS_RR;
      end else begin
         rx_class = CLASS_WR;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         proto_access <= 1'b0;
         test_data    <= '0;
      end else begin
         proto_access <= rx_access & ~test_mode;   // Nothing forwarded in test mode
         if (rx_access && test_mode && rx_write) begin
            test_data <= test_data + rx_packet[DATA_HI:DATA_LO];  // Running checksum
         end
      end
   end

   // Payload only captured with a valid beat
   always_ff @(posedge clk) begin
      if (rx_access) begin
         proto_class  <= rx_class;
         proto_packet <= rx_packet;
      end
   end

endmodule

/* erx_pkg.sv */
package erx_pkg;

   localparam int PW   = 104;            // Mesh packet width
   localparam int AW   = 32;             // Address width
   localparam int DW   = 32;             // Data width
   localparam int ID_W = 12;             // Chip id / remap field width

   localparam logic [ID_W-1:0] ELINK_ID = 12'h999;  // This chip

   // Packet fields, top bit down
   localparam int WRITE_BIT   = 103;
   localparam int DATAMODE_HI = 102;
   localparam int DATAMODE_LO = 101;
   localparam int CTRLMODE_HI = 100;
   localparam int CTRLMODE_LO = 96;
   localparam int DST_HI      = 95;
   localparam int DST_LO      = 64;
   localparam int DATA_HI     = 63;
   localparam int DATA_LO     = 32;
   localparam int SRC_HI      = 31;
   localparam int SRC_LO      = 0;

   localparam logic [1:0] DATAMODE_32 = 2'd2;   // Single word
   localparam logic [1:0] DATAMODE_64 = 2'd3;   // Double word, upper in srcfield

   // Third packet word, meaning depends on the transaction
   typedef union packed {
      logic [AW-1:0] rd_return_addr;    // Read, where the response goes
      logic [DW-1:0] wr_data_hi;        // 64-bit write, upper data
   } erx_srcfield_u;

   // Class codes double as channel index
   localparam logic [1:0] CLASS_WR = 2'd0;
   localparam logic [1:0] CLASS_RD = 2'd1;
   localparam logic [1:0] CLASS_RR = 2'd2;

   localparam int FIFO_DEPTH      = 8;
   localparam int FIFO_AW         = 3;  // Pointer width, wraps at depth
   localparam int FIFO_CW         = 4;  // Count 0..8
   localparam int FIFO_HIGH_WATER = 6;  // Leaves room for two in flight

   // Register offset from cfg dstaddr 5:2
   localparam int REG_ADDR_HI = DST_LO + 5;
   localparam int REG_ADDR_LO = DST_LO + 2;

   localparam logic [3:0] REG_CFG           = 4'd0;
   localparam logic [3:0] REG_REMAP_SEL     = 4'd1;
   localparam logic [3:0] REG_REMAP_PATTERN = 4'd2;
   localparam logic [3:0] REG_STATUS        = 4'd3;
   localparam logic [3:0] REG_TEST_DATA     = 4'd4;
   localparam logic [3:0] REG_MAILBOX_LO    = 4'd5;
   localparam logic [3:0] REG_MAILBOX_HI    = 4'd6;

   // REG_CFG bits
   localparam int CFG_TEST_MODE = 0;
   localparam int CFG_REMAP_EN  = 1;
   localparam int CFG_IRQ_EN    = 2;

endpackage
